// ==== tb.f ====
source/bridge_cfg_pkg.sv
source/mm_types_pkg.sv
source/mm_fifo.sv
source/mm_master_issuer.sv
source/mm_bridge.sv
bench/mm_slave_model.sv
bench/mm_bridge_tb.sv

// ==== Makefile ====
SIM       = verilator
FLAGS     = --binary --assert -Wno-fatal
LINTFLAGS = --lint-only --timing --assert -Wall
TOP       = mm_bridge_tb
FILELIST  = tb.f
OBJDIR    = obj_dir
LOG       = sim.log
FAIL_MSG  = Finished with errors
PASS_MSG  = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not complete"; exit 1)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== bench/mm_bridge_tb.sv ====
// bridge testbench that runs an operation table through the host port and checks every read beat
`default_nettype none

module mm_bridge_tb;
    import bridge_cfg_pkg::*;
    import mm_types_pkg::*;

    // one host operation
    // duty is readready slots out of every 4 cycles
    typedef struct packed {
        logic is_write;
        mm_addr_t addr;
        mm_burst_t burst;
        mm_data_t data;
        mm_byteen_t be;
        logic [2:0] duty;
    } op_t;

    localparam int CYCLES_PER_OP = 200;

    logic m0_clk;
    logic m0_reset;
    logic m0_read;
    logic m0_write;
    logic m0_waitrequest;
    logic m0_readdatavalid;
    logic s0_read;
    logic s0_write;
    logic s0_waitrequest;
    logic s0_readdatavalid;
    logic s0_readready = 1'b1;
    mm_addr_t s0_address;
    mm_addr_t m0_address;
    mm_burst_t s0_burstcount;
    mm_burst_t m0_burstcount;
    mm_data_t s0_writedata;
    mm_data_t s0_readdata;
    mm_data_t m0_writedata;
    mm_data_t m0_readdata;
    mm_byteen_t s0_byteenable;
    mm_byteen_t m0_byteenable;

    op_t ops [$];
    // expected memory contents and read beats still owed in issue order
    mm_data_t shadow [256];
    mm_data_t expected [$];
    logic [2:0] duty;
    int ctrl_errors;
    int beat_errors;
    int beats_seen;
    int beats_owed;
    int limit;
    int cycle = 0;

    mm_bridge uut (.*);
    mm_slave_model slave (.*);

    initial begin
        m0_clk = 1'b0;
        forever #10 m0_clk = ~m0_clk;
    end

    function automatic op_t make_op(input logic w, input mm_addr_t a, input mm_burst_t n,
                                    input mm_data_t d, input mm_byteen_t be,
                                    input logic [2:0] dy);
        make_op = {w, a, n, d, be, dy};
    endfunction

    // --------------------
    // operation table
    // --------------------
    task automatic build_table();
        // reset pattern then full-lane write and read back
        ops.push_back(make_op(1'b0, 8'h10, 3'd1, '0, '0, 3'd4));
        ops.push_back(make_op(1'b0, 8'h11, 3'd1, '0, '0, 3'd4));
        ops.push_back(make_op(1'b1, 8'h20, 3'd1, 32'ha5a5_a5a5, 4'hf, 3'd4));
        ops.push_back(make_op(1'b0, 8'h20, 3'd1, '0, '0, 3'd4));
        // partial lanes on bytes 0 and 2 then byte 3
        ops.push_back(make_op(1'b1, 8'h21, 3'd1, 32'hdead_beef, 4'b0101, 3'd4));
        ops.push_back(make_op(1'b1, 8'h21, 3'd1, 32'h7700_0000, 4'b1000, 3'd3));
        ops.push_back(make_op(1'b0, 8'h21, 3'd1, '0, '0, 3'd3));
        // one burst of each length
        for (int n = 1; n <= MAX_BURST; n++) begin
            ops.push_back(make_op(1'b0, mm_addr_t'(8'h40 + 8 * n), mm_burst_t'(n), '0, '0, 3'd2));
        end
        // write then a burst across it
        ops.push_back(make_op(1'b1, 8'h61, 3'd1, 32'h1234_5678, 4'hf, 3'd4));
        ops.push_back(make_op(1'b0, 8'h60, 3'd4, '0, '0, 3'd4));
        // streaming bursts with readready mostly low
        for (int i = 0; i < 10; i++) begin
            ops.push_back(make_op(1'b0, mm_addr_t'(8'h80 + 4 * i), 3'd4, '0, '0, 3'd1));
        end
        ops.push_back(make_op(1'b1, 8'h84, 3'd1, 32'hcafe_f00d, 4'hf, 3'd1));
        ops.push_back(make_op(1'b0, 8'h84, 3'd1, '0, '0, 3'd1));
    endtask

    // drive one command and hold it until taken
    task automatic apply_op(input op_t op);
        mm_data_t mask;
        duty <= op.duty;
        s0_address = op.addr;
        s0_burstcount = op.burst;
        s0_writedata = op.data;
        s0_byteenable = op.be;
        s0_read = ~op.is_write;
        s0_write = op.is_write;
        while (s0_waitrequest) @(negedge m0_clk);
        // taken on the coming rising edge
        if (op.is_write) begin
            for (int b = 0; b < BYTEEN_WIDTH; b++) begin
                mask[b*SYMBOL_WIDTH +: SYMBOL_WIDTH] = {SYMBOL_WIDTH{op.be[b]}};
            end
            shadow[op.addr] = (shadow[op.addr] & ~mask) | (op.data & mask);
        end else begin
            for (int i = 0; i < int'(op.burst); i++) begin
                expected.push_back(shadow[op.addr + mm_addr_t'(i)]);
            end
            beats_owed += int'(op.burst);
        end
        @(negedge m0_clk);
    endtask

    task automatic expect_low(input string name, input logic value);
        assert (value == 1'b0) else begin
            ctrl_errors++;
            $display("FAILED %s: got %h, expected %h", name, value, 1'b0);
        end
    endtask

    // readready duty pattern changed on the falling edge
    always @(negedge m0_clk) begin
        cycle <= cycle + 1;
        s0_readready <= ((cycle % 4) < int'(duty));
    end

    // --------------------
    // response check
    // --------------------
    always @(posedge m0_clk) begin
        if (!m0_reset && s0_readdatavalid && s0_readready) begin
            beats_seen <= beats_seen + 1;
            assert (expected.size() != 0) else begin
                beat_errors++;
                $display("read beat arrived with no read outstanding, data %h", s0_readdata);
            end
            if (expected.size() != 0) begin
                assert (s0_readdata == expected[0]) else begin
                    beat_errors++;
                    $display("FAILED s0_readdata: got %h, expected %h", s0_readdata, expected[0]);
                end
                void'(expected.pop_front());
            end
        end
    end

    initial begin
        m0_reset = 1'b1;
        s0_address = '0;
        s0_burstcount = '0;
        s0_writedata = '0;
        s0_byteenable = '0;
        s0_read = 1'b0;
        s0_write = 1'b0;
        duty <= 3'd4;
        ctrl_errors = 0;
        beat_errors = 0;
        beats_seen = 0;
        beats_owed = 0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = 32'(i) * 32'h0101_0101;
        end
        build_table();
        limit = (ops.size() + 2) * CYCLES_PER_OP;
        // eight rising edges with reset held
        repeat (8) @(posedge m0_clk);
        @(negedge m0_clk);
        m0_reset = 1'b0;
        @(negedge m0_clk);
        expect_low("s0_readdatavalid", s0_readdatavalid);
        expect_low("m0_read", m0_read);
        expect_low("m0_write", m0_write);
        while (s0_waitrequest) @(negedge m0_clk);
        foreach (ops[i]) begin
            apply_op(ops[i]);
        end
        s0_read = 1'b0;
        s0_write = 1'b0;
        duty <= 3'd4;
        while (expected.size() != 0) @(negedge m0_clk);
        // idle a while so stray beats show up
        repeat (8) @(negedge m0_clk);
        assert (beats_seen == beats_owed) else begin
            ctrl_errors++;
            $display("FAILED read beat count: got %h, expected %h", beats_seen, beats_owed);
        end
        $display("errors: %0d control, %0d read data; beats %0d of %0d",
                 ctrl_errors, beat_errors, beats_seen, beats_owed);
        if (ctrl_errors == 0 && beat_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog with its limit set from the table length at time zero
    initial begin
        #1;
        repeat (limit) @(posedge m0_clk);
        $display("timeout after %0d cycles with %0d read beats still owed", limit, expected.size());
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/mm_slave_model.sv ====
// behavioral memory on the bridge master port with random stalls and random read latency
`default_nettype none

module mm_slave_model (
    input  wire logic m0_clk,
    input  wire logic m0_reset,
    input  wire mm_types_pkg::mm_addr_t m0_address,
    input  wire mm_types_pkg::mm_burst_t m0_burstcount,
    input  wire mm_types_pkg::mm_data_t m0_writedata,
    input  wire mm_types_pkg::mm_byteen_t m0_byteenable,
    input  wire logic m0_read,
    input  wire logic m0_write,
    output logic m0_waitrequest,
    output mm_types_pkg::mm_data_t m0_readdata,
    output logic m0_readdatavalid
);
    import bridge_cfg_pkg::*;
    import mm_types_pkg::*;

    mm_data_t mem [256];
    // beats owed to the master with data captured at accept
    mm_data_t beat_data [$];
    // idle cycles left before each beat
    // nonzero only on a burst's first beat
    int beat_gap [$];

    initial begin
        void'($urandom(85));
        // every word starts as its address in all four bytes
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'(i) * 32'h0101_0101;
        end
    end

    always @(posedge m0_clk or posedge m0_reset) begin
        mm_data_t mask;
        if (m0_reset) begin
            m0_waitrequest <= 1'b1;
            m0_readdatavalid <= 1'b0;
            m0_readdata <= '0;
            beat_data.delete();
            beat_gap.delete();
        end else begin
            // --------------------
            // command accept
            // --------------------
            if (m0_write && !m0_waitrequest) begin
                for (int b = 0; b < BYTEEN_WIDTH; b++) begin
                    mask[b*SYMBOL_WIDTH +: SYMBOL_WIDTH] = {SYMBOL_WIDTH{m0_byteenable[b]}};
                end
                mem[m0_address] = (mem[m0_address] & ~mask) | (m0_writedata & mask);
            end
            if (m0_read && !m0_waitrequest) begin
                // consecutive words with 1 to 4 cycles until the first beat
                for (int i = 0; i < int'(m0_burstcount); i++) begin
                    beat_data.push_back(mem[m0_address + mm_addr_t'(i)]);
                    beat_gap.push_back((i == 0) ? int'($urandom_range(3, 0)) : 0);
                end
            end
            // --------------------
            // read beats
            // --------------------
            // never stalled once started
            m0_readdatavalid <= 1'b0;
            if (beat_data.size() != 0) begin
                if (beat_gap[0] > 0) begin
                    beat_gap[0] = beat_gap[0] - 1;
                end else begin
                    m0_readdatavalid <= 1'b1;
                    m0_readdata <= beat_data.pop_front();
                    void'(beat_gap.pop_front());
                end
            end
            // stall about one cycle in four
            m0_waitrequest <= ($urandom_range(3, 0) == 0);
        end
    end

endmodule

`default_nettype wire

// ==== source/mm_bridge.sv ====
// bridge top level, host slave port to memory master port through command and response FIFOs
`default_nettype none

module mm_bridge (
    input  wire logic m0_clk,
    input  wire logic m0_reset,

    // host-side slave
    input  wire mm_types_pkg::mm_addr_t s0_address,
    input  wire mm_types_pkg::mm_burst_t s0_burstcount,
    input  wire mm_types_pkg::mm_data_t s0_writedata,
    input  wire mm_types_pkg::mm_byteen_t s0_byteenable,
    input  wire logic s0_read,
    input  wire logic s0_write,
    output logic s0_waitrequest,
    output mm_types_pkg::mm_data_t s0_readdata,
    output logic s0_readdatavalid,
    input  wire logic s0_readready,

    // memory-side master
    output mm_types_pkg::mm_addr_t m0_address,
    output mm_types_pkg::mm_burst_t m0_burstcount,
    output mm_types_pkg::mm_data_t m0_writedata,
    output mm_types_pkg::mm_byteen_t m0_byteenable,
    output logic m0_read,
    output logic m0_write,
    input  wire logic m0_waitrequest,
    input  wire mm_types_pkg::mm_data_t m0_readdata,
    input  wire logic m0_readdatavalid
);
    import bridge_cfg_pkg::*;
    import mm_types_pkg::*;

    mm_cmd_t s0_cmd;
    mm_cmd_t cmd_head;
    logic cmd_in_ready;
    logic cmd_head_valid;
    logic cmd_head_ready;
    logic [PENDING_WIDTH-1:0] rsp_space;

    // --------------------
    // host command packing
    // --------------------
    assign s0_cmd.address = s0_address;
    assign s0_cmd.burstcount = s0_burstcount;
    assign s0_cmd.read = s0_read;
    assign s0_cmd.write = s0_write;
    assign s0_cmd.writedata = s0_writedata;
    assign s0_cmd.byteenable = s0_byteenable;

    // host stalls only on a full command FIFO
    assign s0_waitrequest = ~cmd_in_ready;

    mm_fifo #(
        .WIDTH($bits(mm_cmd_t)),
        .DEPTH(CMD_FIFO_DEPTH)
    ) cmd_fifo (
        .m0_clk(m0_clk),
        .m0_reset(m0_reset),
        .in_data(s0_cmd),
        .in_valid(s0_read | s0_write),
        .in_ready(cmd_in_ready),
        .out_data(cmd_head),
        .out_valid(cmd_head_valid),
        .out_ready(cmd_head_ready),
        .space()
    );

    // --------------------
    // issue and response
    // --------------------
    mm_master_issuer issuer (
        .m0_clk(m0_clk),
        .m0_reset(m0_reset),
        .cmd(cmd_head),
        .cmd_valid(cmd_head_valid),
        .cmd_ready(cmd_head_ready),
        .rsp_space(rsp_space),
        .m0_address(m0_address),
        .m0_burstcount(m0_burstcount),
        .m0_writedata(m0_writedata),
        .m0_byteenable(m0_byteenable),
        .m0_read(m0_read),
        .m0_write(m0_write),
        .m0_waitrequest(m0_waitrequest),
        .m0_readdatavalid(m0_readdatavalid)
    );

    // memory beats cannot be stalled, so overflow is checked here
    mm_fifo #(
        .WIDTH(DATA_WIDTH),
        .DEPTH(RSP_FIFO_DEPTH),
        .MUST_ACCEPT(1'b1)
    ) rsp_fifo (
        .m0_clk(m0_clk),
        .m0_reset(m0_reset),
        .in_data(m0_readdata),
        .in_valid(m0_readdatavalid),
        .in_ready(),
        .out_data(s0_readdata),
        .out_valid(s0_readdatavalid),
        .out_ready(s0_readready),
        .space(rsp_space)
    );

endmodule

`default_nettype wire

// ==== source/mm_master_issuer.sv ====
// master-port command issue from the command FIFO head, with read throttling on response space
`default_nettype none

module mm_master_issuer (
    input  wire logic m0_clk,
    input  wire logic m0_reset,

    // command FIFO head
    input  wire mm_types_pkg::mm_cmd_t cmd,
    input  wire logic cmd_valid,
    output logic cmd_ready,

    // free slots in the response FIFO
    input  wire logic [bridge_cfg_pkg::PENDING_WIDTH-1:0] rsp_space,

    // memory-side master
    output mm_types_pkg::mm_addr_t m0_address,
    output mm_types_pkg::mm_burst_t m0_burstcount,
    output mm_types_pkg::mm_data_t m0_writedata,
    output mm_types_pkg::mm_byteen_t m0_byteenable,
    output logic m0_read,
    output logic m0_write,
    input  wire logic m0_waitrequest,
    input  wire logic m0_readdatavalid
);
    import bridge_cfg_pkg::*;
    import mm_types_pkg::*;

    logic head_read;
    logic head_write;
    logic read_accepted;
    logic any_accepted;
    // read words requested but not yet returned
    logic [PENDING_WIDTH-1:0] pending;
    logic [PENDING_WIDTH-1:0] pending_next;
    // one extra bit so the margin never wraps
    logic [PENDING_WIDTH:0] pending_margin;
    logic stop_cmd;
    logic stop_cmd_r;
    // read already on the bus and stalled
    logic held_read;

    // --------------------
    // command unpack
    // --------------------
    assign m0_address = cmd.address;
    assign m0_burstcount = cmd.burstcount;
    assign m0_writedata = cmd.writedata;
    assign m0_byteenable = cmd.byteenable;

    assign head_read = cmd_valid & cmd.read;
    assign head_write = cmd_valid & cmd.write;

    // writes go straight out
    assign m0_write = head_write;
    // reads wait out the throttle unless already shown
    assign m0_read = head_read & (~stop_cmd_r | held_read);

    // pop only what the slave took
    assign any_accepted = (m0_read | m0_write) & ~m0_waitrequest;
    assign cmd_ready = any_accepted;
    assign read_accepted = m0_read & ~m0_waitrequest;

    // --------------------
    // pending read words
    // --------------------
    // add whole burst on accept, retire one word per beat
    always_comb begin
        pending_next = pending;
        if (read_accepted) begin
            pending_next = pending_next + PENDING_WIDTH'(cmd.burstcount);
        end
        if (m0_readdatavalid) begin
            pending_next = pending_next - 1'b1;
        end
    end

    // two bursts of slack cover the registered flag lag
    assign pending_margin = {1'b0, pending} + (PENDING_WIDTH + 1)'(2 * MAX_BURST);
    assign stop_cmd = pending_margin > {1'b0, rsp_space};

    always_ff @(posedge m0_clk or posedge m0_reset) begin
        if (m0_reset) begin
            pending <= '0;
            stop_cmd_r <= 1'b0;
            held_read <= 1'b0;
        end else begin
            pending <= pending_next;
            stop_cmd_r <= stop_cmd;
            held_read <= m0_read & m0_waitrequest;
        end
    end

    // --------------------
    // checks
    // --------------------
    // every outstanding word must have a slot waiting for it
    a_pending_fits: assert property (
        @(posedge m0_clk) disable iff (m0_reset)
        pending <= rsp_space
    ) else $error("%m: pending reads %0d exceed response space %0d", pending, rsp_space);

    // a stalled read is never withdrawn or changed
    a_read_held: assert property (
        @(posedge m0_clk) disable iff (m0_reset)
        (m0_read && m0_waitrequest) |=> (m0_read && $stable(m0_address))
    ) else $error("%m: m0_read dropped before it was accepted");

endmodule

`default_nettype wire

// ==== source/mm_fifo.sv ====
// synchronous valid/ready FIFO with free-space count, used for commands and read data
`default_nettype none

module mm_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4,
    // set where the producer cannot be stalled
    parameter bit MUST_ACCEPT = 1'b0
) (
    input  wire logic m0_clk,
    input  wire logic m0_reset,

    input  wire logic [WIDTH-1:0] in_data,
    input  wire logic in_valid,
    output logic in_ready,

    output logic [WIDTH-1:0] out_data,
    output logic out_valid,
    input  wire logic out_ready,

    output logic [bridge_cfg_pkg::PENDING_WIDTH-1:0] space
);
    import bridge_cfg_pkg::*;

    // --------------------
    // storage and pointers
    // --------------------
    logic [WIDTH-1:0] mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    // occupancy, 0..DEPTH
    logic [PENDING_WIDTH-1:0] count;
    logic push;
    logic pop;

    // full only when every slot is taken
    assign in_ready = (count != PENDING_WIDTH'(DEPTH));
    assign out_valid = (count != '0);
    // head word read straight from the array
    assign out_data = mem[rd_ptr];
    assign space = PENDING_WIDTH'(DEPTH) - count;

    // transfer on valid and ready together
    assign push = in_valid & in_ready;
    assign pop = out_valid & out_ready;

    // --------------------
    // control
    // --------------------
    always_ff @(posedge m0_clk or posedge m0_reset) begin
        if (m0_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            // explicit wrap, depth need not be a power of two
            if (push) begin
                wr_ptr <= (wr_ptr == $clog2(DEPTH)'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == $clog2(DEPTH)'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves occupancy alone
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // payload array
    always_ff @(posedge m0_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // --------------------
    // checks
    // --------------------
    // a producer without back-pressure must never meet a full FIFO
    // for read data this means the upstream throttle failed
    a_no_overflow: assert property (
        @(posedge m0_clk) disable iff (m0_reset)
        (MUST_ACCEPT && in_valid) |-> in_ready
    ) else $error("%m: response FIFO overflow, a word arrived while full");

endmodule

`default_nettype wire

// ==== source/mm_types_pkg.sv ====
// bus field types and the packed command word carried through the command FIFO
`default_nettype none

package mm_types_pkg;

    // --------------------
    // field widths
    // --------------------
    // word address on both ports
    typedef logic [bridge_cfg_pkg::ADDRESS_WIDTH-1:0] mm_addr_t;

    // one data beat
    typedef logic [bridge_cfg_pkg::DATA_WIDTH-1:0] mm_data_t;

    // one enable bit per byte lane
    typedef logic [bridge_cfg_pkg::BYTEEN_WIDTH-1:0] mm_byteen_t;

    // words per read burst
    typedef logic [bridge_cfg_pkg::BURSTCOUNT_WIDTH-1:0] mm_burst_t;

    // --------------------
    // command word
    // --------------------
    // one host transaction, read or write
    // writedata and byteenable are don't-care for reads
    typedef struct packed {
        mm_addr_t   address;
        mm_burst_t  burstcount;
        logic       read;
        logic       write;
        mm_data_t   writedata;
        mm_byteen_t byteenable;
    } mm_cmd_t;

endpackage

`default_nettype wire

// ==== source/bridge_cfg_pkg.sv ====
// bridge sizing constants, imported by every bridge module and by the testbench
`default_nettype none

package bridge_cfg_pkg;

    // --------------------
    // bus geometry
    // --------------------
    // data bus and byte lanes
    localparam int DATA_WIDTH = 32;
    localparam int SYMBOL_WIDTH = 8;
    localparam int BYTEEN_WIDTH = DATA_WIDTH / SYMBOL_WIDTH;

    // word addressing, 256 words
    localparam int ADDRESS_WIDTH = 8;

    // burstcount field holds 1..MAX_BURST
    localparam int BURSTCOUNT_WIDTH = 3;
    localparam int MAX_BURST = 4;

    // --------------------
    // buffering
    // --------------------
    localparam int CMD_FIFO_DEPTH = 4;
    localparam int RSP_FIFO_DEPTH = 16;

    // must hold RSP_FIFO_DEPTH itself, not just depth-1
    localparam int PENDING_WIDTH = $clog2(RSP_FIFO_DEPTH) + 1;

endpackage

`default_nettype wire
